/* common/dcachePkg.sv */
// cache geometry, field types and shared structs that every block refers to by scoped name
package dcachePkg;

	localparam int ADDR_W = 32;
	localparam int WORD_W = 32;
	localparam int WORDS_PER_LINE = 16;
	localparam int LINE_W = WORD_W * WORDS_PER_LINE;
	localparam int SETS = 16;
	localparam int INDEX_W = $clog2(SETS);
	localparam int OFFSET_W = $clog2(LINE_W / 8);
	localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

	typedef logic [ADDR_W-1:0] addrT;
	typedef logic [WORD_W-1:0] wordT;
	typedef logic [LINE_W-1:0] lineT;
	typedef logic [TAG_W-1:0] tagT;
	typedef logic [INDEX_W-1:0] indexT;
	typedef logic [$clog2(WORDS_PER_LINE)-1:0] wordSelT;
	typedef logic wayT;

	typedef enum logic [1:0] {
		OP_NONE = 2'd0,
		OP_READ = 2'd1,
		OP_WRITE = 2'd2
	} cpuOpT;

	// status codes as the requester sees them
	typedef enum logic [1:0] {
		ST_WAITING = 2'd1,
		ST_HIT = 2'd2,
		ST_MISS = 2'd3
	} statusT;

	typedef struct packed {
		logic valid;
		logic lru; // set means next victim
		logic dirty;
	} lineStateT;

	typedef struct packed {
		cpuOpT op;
		addrT addr;
		wordT wdata;
	} cpuReqT;

	typedef struct packed {
		logic hit;
		wayT hitWay;
		wayT victimWay;
		logic victimDirty;
		tagT victimTag;
	} lookupT;

	typedef struct packed {
		logic writeWord;
		logic fillLine;
		logic cleanLine;
		logic invalidate;
		logic touch;
		wayT way;
		indexT index;
		wordSelT wordSel;
		wordT word;
		tagT tag;
		lineT line;
	} storeCmdT;

	typedef struct packed {
		logic fill;
		logic writeback;
		addrT lineAddr;
		lineT line;
	} memReqT;

	typedef struct packed {
		logic fillDone;
		logic wbDone;
		lineT line;
	} memRespT;

	function automatic tagT addrTag(input addrT a);
		return a[ADDR_W-1 -: TAG_W];
	endfunction

	function automatic indexT addrIndex(input addrT a);
		return a[OFFSET_W +: INDEX_W];
	endfunction

	// word number with the byte bits dropped
	function automatic wordSelT addrWord(input addrT a);
		return a[OFFSET_W-1 -: $bits(wordSelT)];
	endfunction

	function automatic addrT lineBase(input tagT t, input indexT i);
		return {t, i, {OFFSET_W{1'b0}}};
	endfunction

endpackage

/* dcache/cacheStore.sv */
// tag, state and data arrays of both ways; reads the addressed set and applies store commands
`timescale 1ns/10ps

module cacheStore (
	input logic clk,
	input logic reset,
	input dcachePkg::indexT index,
	input dcachePkg::wordSelT wordSel,
	input dcachePkg::storeCmdT cmd,
	output dcachePkg::tagT [1:0] tags,
	output dcachePkg::lineStateT [1:0] states,
	output dcachePkg::wordT readWord,
	input dcachePkg::wayT hitWay,
	output dcachePkg::lineT victimLine,
	input dcachePkg::wayT victimWay
);

	dcachePkg::lineT dataMem [2][dcachePkg::SETS];
	dcachePkg::tagT tagMem [2][dcachePkg::SETS];
	dcachePkg::lineStateT stateMem [2][dcachePkg::SETS];
	dcachePkg::lineT hitLine;

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			tags[w] = tagMem[w][index];
			states[w] = stateMem[w][index];
		end
	end

	assign hitLine = dataMem[hitWay][index];
	assign readWord = hitLine[wordSel*dcachePkg::WORD_W +: dcachePkg::WORD_W];
	assign victimLine = dataMem[victimWay][index]; // source for write-back

	always_ff @(posedge clk) begin
		if (cmd.fillLine) begin
			dataMem[cmd.way][cmd.index] <= cmd.line;
			tagMem[cmd.way][cmd.index] <= cmd.tag;
		end else if (cmd.writeWord) begin
			dataMem[cmd.way][cmd.index][cmd.wordSel*dcachePkg::WORD_W +: dcachePkg::WORD_W]
				<= cmd.word;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int w = 0; w < 2; w++) begin
				for (int s = 0; s < dcachePkg::SETS; s++) begin
					stateMem[w][s] <= '0;
				end
			end
		end else begin
			if (cmd.fillLine) begin
				stateMem[cmd.way][cmd.index].valid <= 1'b1;
				stateMem[cmd.way][cmd.index].dirty <= 1'b0;
			end
			if (cmd.writeWord) begin
				stateMem[cmd.way][cmd.index].dirty <= 1'b1;
			end
			if (cmd.cleanLine) begin
				stateMem[cmd.way][cmd.index].dirty <= 1'b0; // after write-back
			end
			if (cmd.invalidate) begin
				// dirty data is simply lost
				stateMem[cmd.way][cmd.index].valid <= 1'b0;
				stateMem[cmd.way][cmd.index].dirty <= 1'b0;
			end
			if (cmd.touch) begin
				stateMem[cmd.way][cmd.index].lru <= 1'b0;
				stateMem[~cmd.way][cmd.index].lru <= 1'b1; // other way is next victim
			end
		end
	end

endmodule

/* dcache/wayLookup.sv */
// combinational tag compare over both ways, plus LRU victim pick and its dirty state
`timescale 1ns/10ps

module wayLookup (
	input dcachePkg::addrT addr,
	input dcachePkg::tagT [1:0] tags,
	input dcachePkg::lineStateT [1:0] states,
	output dcachePkg::lookupT result
);

	dcachePkg::tagT reqTag;
	logic [1:0] wayHit;
	dcachePkg::wayT victim;

	assign reqTag = dcachePkg::addrTag(addr);

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			wayHit[w] = states[w].valid && (tags[w] == reqTag);
		end
	end

	// way 0 only when its lru bit says so
	assign victim = states[0].lru ? 1'b0 : 1'b1;

	always_comb begin
		result.hit = |wayHit;
		result.hitWay = !wayHit[0];
		result.victimWay = victim;
		result.victimDirty = states[victim].valid && states[victim].dirty;
		result.victimTag = tags[victim]; // forms write-back address
	end

endmodule

/* dcache/missControl.sv */
// request and miss FSM; decides status, builds store commands and issues memory requests
`timescale 1ns/10ps

module missControl (
	input logic clk,
	input logic reset,
	input dcachePkg::cpuReqT cpuReq,
	input logic inval,
	input dcachePkg::addrT invalAddr,
	input dcachePkg::lookupT look,
	input dcachePkg::lineT victimLine,
	input dcachePkg::memRespT memResp,
	output dcachePkg::statusT status,
	output dcachePkg::storeCmdT cmd,
	output dcachePkg::memReqT memReq
);

	typedef enum logic [1:0] {
		IDLE,
		WB_WAIT,
		FILL_WAIT
	} ctlStateT;

	ctlStateT state;
	ctlStateT nextState;
	dcachePkg::indexT reqIndex;
	dcachePkg::indexT missIndex;
	dcachePkg::wayT missWay;
	dcachePkg::tagT missTag;
	logic issueFill;
	logic issueWb;
	logic reqFill;
	logic reqWb;
	dcachePkg::addrT reqLineAddr;
	dcachePkg::lineT reqLine;

	assign reqIndex = dcachePkg::addrIndex(cpuReq.addr);

	always_comb begin
		status = dcachePkg::ST_MISS;
		cmd = '0;
		nextState = state;
		issueFill = 1'b0;
		issueWb = 1'b0;
		case (state)
			IDLE: begin
				if (inval) begin
					cmd.invalidate = look.hit; // lookup runs on invalAddr here
					cmd.way = look.hitWay;
					cmd.index = dcachePkg::addrIndex(invalAddr);
				end else if (cpuReq.op != dcachePkg::OP_NONE) begin
					if (look.hit) begin
						status = dcachePkg::ST_HIT;
						cmd.touch = 1'b1;
						cmd.way = look.hitWay;
						cmd.index = reqIndex;
						cmd.writeWord = (cpuReq.op == dcachePkg::OP_WRITE);
						cmd.wordSel = dcachePkg::addrWord(cpuReq.addr);
						cmd.word = cpuReq.wdata;
					end else if (look.victimDirty) begin
						issueWb = 1'b1;
						nextState = WB_WAIT;
					end else begin
						issueFill = 1'b1;
						nextState = FILL_WAIT;
					end
				end
			end
			WB_WAIT: begin
				status = dcachePkg::ST_WAITING;
				if (memResp.wbDone) begin
					// lookup sees a clean victim once back in idle
					cmd.cleanLine = 1'b1;
					cmd.way = missWay;
					cmd.index = missIndex;
					nextState = IDLE;
				end
			end
			FILL_WAIT: begin
				status = dcachePkg::ST_WAITING;
				if (memResp.fillDone) begin
					cmd.fillLine = 1'b1;
					cmd.touch = 1'b1;
					cmd.way = missWay;
					cmd.index = missIndex;
					cmd.tag = missTag;
					cmd.line = memResp.line;
					nextState = IDLE;
				end
			end
			default: nextState = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			reqFill <= 1'b0;
			reqWb <= 1'b0;
		end else begin
			state <= nextState;
			reqFill <= issueFill;
			reqWb <= issueWb;
		end
	end

	// miss context held through the wait states
	always_ff @(posedge clk) begin
		if (issueFill || issueWb) begin
			missIndex <= reqIndex;
			missWay <= look.victimWay;
			missTag <= dcachePkg::addrTag(cpuReq.addr);
		end
		if (issueWb) begin
			reqLineAddr <= dcachePkg::lineBase(look.victimTag, reqIndex);
			reqLine <= victimLine;
		end else if (issueFill) begin
			reqLineAddr <= dcachePkg::lineBase(dcachePkg::addrTag(cpuReq.addr), reqIndex);
		end
	end

	assign memReq = '{
		fill: reqFill,
		writeback: reqWb,
		lineAddr: reqLineAddr,
		line: reqLine
	};

endmodule

/* verilog/dcacheTop.sv */
// data cache top level; connects storage, way lookup and miss controller to requester and memory
`timescale 1ns/10ps

module dcacheTop (
	input logic clk,
	input logic reset,
	input dcachePkg::cpuReqT cpuReq,
	input logic inval,
	input dcachePkg::addrT invalAddr,
	output dcachePkg::statusT status,
	output dcachePkg::wordT readData,
	output dcachePkg::memReqT memReq,
	input dcachePkg::memRespT memResp
);

	dcachePkg::addrT lookAddr;
	dcachePkg::tagT [1:0] tags;
	dcachePkg::lineStateT [1:0] states;
	dcachePkg::lookupT look;
	dcachePkg::storeCmdT cmd;
	dcachePkg::lineT victimLine;

	// invalidation takes over the lookup path for its cycle
	assign lookAddr = inval ? invalAddr : cpuReq.addr;

	cacheStore u_cacheStore (
		.clk(clk),
		.reset(reset),
		.index(dcachePkg::addrIndex(lookAddr)),
		.wordSel(dcachePkg::addrWord(cpuReq.addr)),
		.cmd(cmd),
		.tags(tags),
		.states(states),
		.readWord(readData),
		.hitWay(look.hitWay),
		.victimLine(victimLine),
		.victimWay(look.victimWay)
	);

	wayLookup u_wayLookup (
		.addr(lookAddr),
		.tags(tags),
		.states(states),
		.result(look)
	);

	missControl u_missControl (
		.clk(clk),
		.reset(reset),
		.cpuReq(cpuReq),
		.inval(inval),
		.invalAddr(invalAddr),
		.look(look),
		.victimLine(victimLine),
		.memResp(memResp),
		.status(status),
		.cmd(cmd),
		.memReq(memReq)
	);

endmodule

/* verif/dcacheChecker.sv */
// watches the cache ports, keeps a model of both ways and memory, compares and counts errors
`timescale 1ns/10ps

module dcacheChecker (
	input logic clk,
	input logic reset,
	input dcachePkg::cpuReqT cpuReq,
	input logic inval,
	input dcachePkg::addrT invalAddr,
	input dcachePkg::statusT status,
	input dcachePkg::wordT readData,
	input dcachePkg::memReqT memReq,
	input dcachePkg::memRespT memResp,
	output int errors,
	output int checks
);

	logic [21:0] tagM [2][16];
	logic validM [2][16];
	logic lruM [2][16];
	logic dirtyM [2][16];
	dcachePkg::wordT dataM [2][16][16];
	dcachePkg::wordT memM [1024];
	logic expFill;
	logic expWb;
	logic newReq;
	logic missWay;
	logic [3:0] missIdx;
	dcachePkg::addrT missAddr;

	function automatic dcachePkg::wordT backingWord(input logic [9:0] wordAddr);
		return ({22'd0, wordAddr} * 32'h9e37_79b9) ^ 32'h3c5a_a5c3;
	endfunction

	task automatic reportMismatch(input string msg);
		errors++;
		$display("ERR %0t: %s", $time, msg);
	endtask

	task automatic lookup(input dcachePkg::addrT a, output logic hit, output logic way);
		hit = 1'b0;
		way = 1'b0;
		for (int w = 0; w < 2; w++) begin
			if (validM[w][a[9:6]] && tagM[w][a[9:6]] == a[31:10]) begin
				hit = 1'b1;
				way = w[0];
			end
		end
	endtask

	task automatic touch(input logic way, input logic [3:0] idx);
		lruM[way][idx] = 1'b0;
		lruM[!way][idx] = 1'b1; // other way goes next
	endtask

	task automatic checkWriteback();
		dcachePkg::addrT expAddr;
		logic lineOk;
		expAddr = {tagM[missWay][missIdx], missIdx, 6'd0};
		lineOk = 1'b1;
		checks++;
		if (memReq.lineAddr !== expAddr) begin
			reportMismatch($sformatf("write-back to %h, expected %h", memReq.lineAddr, expAddr));
		end
		for (int w = 0; w < 16; w++) begin
			if (memReq.line[w*32 +: 32] !== dataM[missWay][missIdx][w]) lineOk = 1'b0;
			memM[{expAddr[11:6], w[3:0]}] = dataM[missWay][missIdx][w];
		end
		if (!lineOk) reportMismatch($sformatf("write-back line for %h is wrong", expAddr));
	endtask

	task automatic fillLine();
		tagM[missWay][missIdx] = missAddr[31:10];
		validM[missWay][missIdx] = 1'b1;
		dirtyM[missWay][missIdx] = 1'b0;
		for (int w = 0; w < 16; w++) begin
			dataM[missWay][missIdx][w] = memM[{missAddr[11:6], w[3:0]}];
		end
		touch(missWay, missIdx);
	endtask

	initial begin
		errors = 0;
		checks = 0;
		for (int a = 0; a < 1024; a++) memM[a] = backingWord(a[9:0]);
	end

	always @(posedge clk) begin : compare
		logic hit;
		logic way;
		logic [3:0] idx;
		if (reset) begin
			for (int w = 0; w < 2; w++) begin
				for (int s = 0; s < 16; s++) begin
					validM[w][s] = 1'b0;
					lruM[w][s] = 1'b0;
					dirtyM[w][s] = 1'b0;
				end
			end
			expFill = 1'b0;
			expWb = 1'b0;
			newReq = 1'b1;
		end else begin
			checks++;
			if (memReq.fill !== expFill || memReq.writeback !== expWb) begin
				reportMismatch($sformatf("memory pulses fill %b wb %b, expected %b %b",
					memReq.fill, memReq.writeback, expFill, expWb));
			end
			if (memReq.writeback && expWb) checkWriteback();
			if (memReq.fill && expFill && memReq.lineAddr !== {missAddr[31:6], 6'd0}) begin
				reportMismatch($sformatf("fill from %h for request %h", memReq.lineAddr, missAddr));
			end
			expFill = 1'b0;
			expWb = 1'b0;
			if (memResp.wbDone) dirtyM[missWay][missIdx] = 1'b0;
			if (memResp.fillDone) fillLine();
			checks++;
			if (inval) begin
				if (status !== dcachePkg::ST_MISS) reportMismatch("status not miss during invalidation");
				lookup(invalAddr, hit, way);
				if (hit) begin
					validM[way][invalAddr[9:6]] = 1'b0;
					dirtyM[way][invalAddr[9:6]] = 1'b0; // unwritten data dropped
				end
				newReq = 1'b1;
			end else if (cpuReq.op == dcachePkg::OP_NONE) begin
				if (status !== dcachePkg::ST_MISS) reportMismatch("status not miss while idle");
				newReq = 1'b1;
			end else begin
				lookup(cpuReq.addr, hit, way);
				idx = cpuReq.addr[9:6];
				case (status)
					dcachePkg::ST_HIT: begin
						if (!hit) begin
							reportMismatch($sformatf("hit on %h, line not held", cpuReq.addr));
						end else if (cpuReq.op == dcachePkg::OP_READ) begin
							if (readData !== dataM[way][idx][cpuReq.addr[5:2]]) begin
								reportMismatch($sformatf("read %h gave %h, expected %h", cpuReq.addr,
									readData, dataM[way][idx][cpuReq.addr[5:2]]));
							end
							touch(way, idx);
						end else begin
							dataM[way][idx][cpuReq.addr[5:2]] = cpuReq.wdata;
							dirtyM[way][idx] = 1'b1;
							touch(way, idx);
						end
						newReq = 1'b1;
					end
					dcachePkg::ST_MISS: begin
						if (hit) begin
							reportMismatch($sformatf("miss on %h, line is held", cpuReq.addr));
						end else begin
							missWay = lruM[0][idx] ? 1'b0 : 1'b1;
							missIdx = idx;
							missAddr = cpuReq.addr;
							if (validM[missWay][idx] && dirtyM[missWay][idx]) expWb = 1'b1;
							else expFill = 1'b1;
						end
						newReq = 1'b0;
					end
					dcachePkg::ST_WAITING: begin
						if (newReq) reportMismatch($sformatf("request %h began waiting", cpuReq.addr));
						newReq = 1'b0;
					end
					default: reportMismatch($sformatf("unknown status %b", status));
				endcase
			end
		end
	end

endmodule

/* verif/tbDcache.sv */
// testbench top for the data cache; drives random requests, answers memory and reports the result
`timescale 1ns/10ps

module tbDcache;

	localparam logic [31:0] SEED = 32'h6afb_c177;
	localparam int REQUESTS = 600;
	localparam int WAIT_LIMIT = 200;

	logic clk;
	logic reset;
	dcachePkg::cpuReqT cpuReq;
	logic inval;
	dcachePkg::addrT invalAddr;
	dcachePkg::statusT status;
	dcachePkg::wordT readData;
	dcachePkg::memReqT memReq;
	dcachePkg::memRespT memResp;
	dcachePkg::memReqT pending;
	dcachePkg::wordT backing [1024];
	logic [31:0] stimRand;
	logic [31:0] memRand;
	int errors;
	int checks;
	int delay;
	int done;
	logic timedOut;

	dcacheTop u_dcacheTop (
		.clk(clk),
		.reset(reset),
		.cpuReq(cpuReq),
		.inval(inval),
		.invalAddr(invalAddr),
		.status(status),
		.readData(readData),
		.memReq(memReq),
		.memResp(memResp)
	);

	dcacheChecker u_checker (
		.clk(clk),
		.reset(reset),
		.cpuReq(cpuReq),
		.inval(inval),
		.invalAddr(invalAddr),
		.status(status),
		.readData(readData),
		.memReq(memReq),
		.memResp(memResp),
		.errors(errors),
		.checks(checks)
	);

	function automatic logic [31:0] nextRand(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// every bit of the word address changes the pattern
	function automatic dcachePkg::wordT backingWord(input logic [9:0] wordAddr);
		return ({22'd0, wordAddr} * 32'h9e37_79b9) ^ 32'h3c5a_a5c3;
	endfunction

	// four tags, all sets, all words
	function automatic dcachePkg::addrT pickAddr(input logic [31:0] r);
		return {20'd0, r[29:20], 2'b00};
	endfunction

	task automatic holdUntilHit();
		int waited;
		logic hitSeen;
		waited = 0;
		hitSeen = 1'b0;
		while (!hitSeen && !timedOut) begin
			@(posedge clk);
			if (status == dcachePkg::ST_HIT) begin
				hitSeen = 1'b1;
			end else begin
				waited++;
				if (waited >= WAIT_LIMIT) begin
					$display("request for address %h got no hit within %0d cycles",
						cpuReq.addr, WAIT_LIMIT);
					timedOut = 1'b1;
				end
			end
		end
		@(negedge clk);
		cpuReq = '0;
	endtask

	always #20 clk = ~clk;

	// memory model serving one operation at a time
	always begin
		@(negedge clk);
		memResp = '0;
		if (!reset && (memReq.fill || memReq.writeback)) begin
			pending = memReq;
			memRand = nextRand(memRand);
			delay = 1 + memRand[18:16];
			if (pending.writeback) begin
				for (int w = 0; w < 16; w++) begin
					backing[{pending.lineAddr[11:6], w[3:0]}] = pending.line[w*32 +: 32];
				end
			end
			repeat (delay) @(negedge clk);
			memResp.fillDone = pending.fill;
			memResp.wbDone = pending.writeback;
			for (int w = 0; w < 16; w++) begin
				memResp.line[w*32 +: 32] = backing[{pending.lineAddr[11:6], w[3:0]}];
			end
		end
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		cpuReq = '0;
		inval = 1'b0;
		invalAddr = '0;
		memResp = '0;
		pending = '0;
		stimRand = SEED;
		memRand = SEED ^ 32'h5bd1_e995; // separate stream for memory delays
		timedOut = 1'b0;
		done = 0;
		for (int a = 0; a < 1024; a++) begin
			backing[a] = backingWord(a[9:0]);
		end
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		while (done < REQUESTS && !timedOut) begin
			stimRand = nextRand(stimRand);
			if (stimRand[19:16] == 4'd0) begin
				inval = 1'b1;
				invalAddr = pickAddr(stimRand);
				@(negedge clk);
				inval = 1'b0;
			end else if (stimRand[19:16] == 4'd1) begin
				@(negedge clk); // one cycle with op none
			end else begin
				cpuReq.op = stimRand[31] ? dcachePkg::OP_WRITE : dcachePkg::OP_READ;
				cpuReq.addr = pickAddr(stimRand);
				stimRand = nextRand(stimRand);
				cpuReq.wdata = stimRand;
				holdUntilHit();
			end
			done++;
		end
		repeat (4) @(negedge clk);
		$display("%0d requests, %0d checks, %0d errors", done, checks, errors);
		if (timedOut || errors != 0) begin
			$display("TEST FAIL");
		end else begin
			$display("TEST PASS");
		end
		$finish;
	end

endmodule

/* sources.f */
common/dcachePkg.sv
dcache/cacheStore.sv
dcache/wayLookup.sv
dcache/missControl.sv
verilog/dcacheTop.sv
verif/dcacheChecker.sv
verif/tbDcache.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - common/dcachePkg.sv
  - dcache/cacheStore.sv
  - dcache/wayLookup.sv
  - dcache/missControl.sv
  - verilog/dcacheTop.sv
  - target: test
    files:
      - verif/dcacheChecker.sv
      - verif/tbDcache.sv
